// ==== src/elem_dsp_pkg.sv ====
// sample-side types: complex sample, buffered drive word, output sample
`default_nettype none

package elem_dsp_pkg;

	// one complex sample, both parts signed Q1.15
	typedef struct packed {
		logic signed [15:0] x; // in-phase
		logic signed [15:0] y; // quadrature
	} iq_t;

	// word held in the FIFO between sequencer and modulator
	typedef struct packed {
		iq_t  env;  // envelope sample read from the table
		iq_t  amp;  // complex amplitude of the owning command
		logic last; // final sample of the pulse
	} drive_word_t;

	// sample leaving the element
	typedef struct packed {
		iq_t  iq;
		logic last;
	} out_sample_t;

endpackage

`default_nettype wire

// ==== src/elem_cmd_pkg.sv ====
// command-side types: envelope address width, address type, command struct
`default_nettype none

package elem_cmd_pkg;

	// table holds 2**ENV_ADDR_W entries
	localparam int ENV_ADDR_W = 8;

	typedef logic [ENV_ADDR_W-1:0] env_addr_t;

	// one pulse request
	// env_len has one extra bit so a full table length fits
	typedef struct packed {
		env_addr_t         env_start; // first envelope entry, wraps at table end
		logic [ENV_ADDR_W:0] env_len; // number of samples, zero gives no output
		elem_dsp_pkg::iq_t amp;       // complex amplitude applied to every sample
	} elem_cmd_t;

endpackage

`default_nettype wire

// ==== src/env_table.sv ====
// envelope memory: load write port and registered read port
`timescale 1ns/1ns
`default_nettype none

module env_table (
	input  logic                    elem,
	input  logic                    we,
	input  elem_cmd_pkg::env_addr_t wr_addr,
	input  elem_dsp_pkg::iq_t       wr_data,
	input  elem_cmd_pkg::env_addr_t rd_addr,
	output elem_dsp_pkg::iq_t       rd_data
);

	localparam int DEPTH = 2 ** elem_cmd_pkg::ENV_ADDR_W;

	// one complex envelope sample per entry
	elem_dsp_pkg::iq_t mem [DEPTH];

	always_ff @(posedge elem) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// data is ready one cycle after the address
	always_ff @(posedge elem) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== src/pulse_sequencer.sv ====
// producer: command latch, wrapping envelope address counter, credit counter, push
`timescale 1ns/1ns
`default_nettype none

module pulse_sequencer #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                      elem,
	input  logic                      reset,
	input  elem_cmd_pkg::elem_cmd_t   cmd,
	input  logic                      cmd_valid,
	output logic                      cmd_ready,
	output elem_cmd_pkg::env_addr_t   rd_addr,
	input  elem_dsp_pkg::iq_t         rd_data,
	output logic                      push,
	output elem_dsp_pkg::drive_word_t push_word,
	input  logic                      credit_return
);

	localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

	logic                                busy;
	elem_cmd_pkg::env_addr_t             addr_cnt;
	logic [elem_cmd_pkg::ENV_ADDR_W:0]   remain_cnt;
	elem_dsp_pkg::iq_t                   amp_r;
	logic [CRED_W-1:0]                   credit_cnt;
	logic                                issue;
	logic                                issue_d; // table data arrives this cycle
	logic                                last_d;

	assign cmd_ready = ~busy;

	// one address per cycle while samples remain and a FIFO slot is reserved
	assign issue = busy && (remain_cnt != '0) && (credit_cnt != '0);

	assign rd_addr = addr_cnt;

	always_ff @(posedge elem) begin
		if (reset) begin
			busy       <= 1'b0;
			remain_cnt <= '0;
		end else if (cmd_valid && cmd_ready) begin
			busy       <= 1'b1;
			remain_cnt <= cmd.env_len;
		end else if (busy && remain_cnt == '0) begin
			busy <= 1'b0; // final push is on the bus now, or the command was empty
		end else if (issue) begin
			remain_cnt <= remain_cnt - 1'b1;
		end
	end

	always_ff @(posedge elem) begin
		if (cmd_valid && cmd_ready) begin
			addr_cnt <= cmd.env_start;
			amp_r    <= cmd.amp;
		end else if (issue) begin
			addr_cnt <= addr_cnt + 1'b1; // wraps at table end
		end
	end

	// take a credit on issue, get one back per FIFO pop
	always_ff @(posedge elem) begin
		if (reset) begin
			credit_cnt <= CRED_W'(FIFO_DEPTH);
		end else begin
			case ({issue, credit_return})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// delay the issue so it lines up with the table read
	always_ff @(posedge elem) begin
		if (reset) begin
			issue_d <= 1'b0;
			last_d  <= 1'b0;
		end else begin
			issue_d <= issue;
			last_d  <= issue && (remain_cnt == 1);
		end
	end

	assign push           = issue_d;
	assign push_word.env  = rd_data;
	assign push_word.amp  = amp_r;
	assign push_word.last = last_d;

endmodule

`default_nettype wire

// ==== src/credit_fifo.sv ====
// buffer: circular drive-word store with one credit pulse returned per pop
`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                      elem,
	input  logic                      reset,
	input  logic                      push,
	input  elem_dsp_pkg::drive_word_t push_word,
	output logic                      pop_valid,
	output elem_dsp_pkg::drive_word_t pop_word,
	input  logic                      pop_ready,
	output logic                      credit_return
);

	localparam int PTR_W  = $clog2(FIFO_DEPTH);
	localparam int FILL_W = $clog2(FIFO_DEPTH + 1);

	elem_dsp_pkg::drive_word_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]          wr_ptr;
	logic [PTR_W-1:0]          rd_ptr;
	logic [FILL_W-1:0]         fill;
	logic                      pop;

	// pointer step, also for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign pop_valid = (fill != '0);
	assign pop_word  = mem[rd_ptr];
	assign pop       = pop_valid && pop_ready;

	always_ff @(posedge elem) begin
		if (push) begin
			mem[wr_ptr] <= push_word; // space is guaranteed by the credits
		end
	end

	always_ff @(posedge elem) begin
		if (reset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			fill          <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push) wr_ptr <= next_ptr(wr_ptr);
			if (pop)  rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			credit_return <= pop; // slot freed, hand it back
		end
	end

endmodule

`default_nettype wire

// ==== src/amp_modulator.sv ====
// consumer: two-stage complex multiply of envelope by amplitude, global stall
`timescale 1ns/1ns
`default_nettype none

module amp_modulator (
	input  logic                      elem,
	input  logic                      reset,
	input  logic                      pop_valid,
	input  elem_dsp_pkg::drive_word_t pop_word,
	output logic                      pop_ready,
	output elem_dsp_pkg::out_sample_t out,
	output logic                      out_valid,
	input  logic                      out_ready
);

	logic               advance;
	logic               s1_valid;
	logic               s1_last;
	logic signed [31:0] p_xx; // ex*ax
	logic signed [31:0] p_yy; // ey*ay
	logic signed [31:0] p_xy; // ex*ay
	logic signed [31:0] p_yx; // ey*ax
	logic signed [32:0] sum_x;
	logic signed [32:0] sum_y;

	// everything holds while the output is stalled
	assign advance   = ~(out_valid && ~out_ready);
	assign pop_ready = advance;

	always_ff @(posedge elem) begin
		if (advance) begin
			p_xx    <= $signed(pop_word.env.x) * $signed(pop_word.amp.x);
			p_yy    <= $signed(pop_word.env.y) * $signed(pop_word.amp.y);
			p_xy    <= $signed(pop_word.env.x) * $signed(pop_word.amp.y);
			p_yx    <= $signed(pop_word.env.y) * $signed(pop_word.amp.x);
			s1_last <= pop_word.last;
		end
	end

	// full-width sums, bits 30:15 give the shifted and wrapped result
	assign sum_x = 33'(p_xx) - 33'(p_yy);
	assign sum_y = 33'(p_xy) + 33'(p_yx);

	always_ff @(posedge elem) begin
		if (advance) begin
			out.iq.x <= sum_x[30:15];
			out.iq.y <= sum_y[30:15];
			out.last <= s1_last;
		end
	end

	always_ff @(posedge elem) begin
		if (reset) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else if (advance) begin
			s1_valid  <= pop_valid;
			out_valid <= s1_valid;
		end
	end

endmodule

`default_nettype wire

// ==== src/drive_element.sv ====
// top level: envelope table, sequencer, credit FIFO and modulator
`timescale 1ns/1ns
`default_nettype none

module drive_element #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                      elem,
	input  logic                      reset,
	input  logic                      tbl_we,
	input  elem_cmd_pkg::env_addr_t   tbl_addr,
	input  elem_dsp_pkg::iq_t         tbl_data,
	input  elem_cmd_pkg::elem_cmd_t   cmd,
	input  logic                      cmd_valid,
	output logic                      cmd_ready,
	output elem_dsp_pkg::out_sample_t out,
	output logic                      out_valid,
	input  logic                      out_ready
);

	elem_cmd_pkg::env_addr_t   rd_addr;
	elem_dsp_pkg::iq_t         rd_data;
	logic                      push;
	elem_dsp_pkg::drive_word_t push_word;
	logic                      credit_return;
	logic                      pop_valid;
	elem_dsp_pkg::drive_word_t pop_word;
	logic                      pop_ready;

	env_table u_table (
		.elem(elem), .we(tbl_we), .wr_addr(tbl_addr), .wr_data(tbl_data),
		.rd_addr(rd_addr), .rd_data(rd_data)
	);

	pulse_sequencer #(.FIFO_DEPTH(FIFO_DEPTH)) u_seq (
		.elem(elem), .reset(reset), .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.rd_addr(rd_addr), .rd_data(rd_data), .push(push), .push_word(push_word),
		.credit_return(credit_return)
	);

	credit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.elem(elem), .reset(reset), .push(push), .push_word(push_word),
		.pop_valid(pop_valid), .pop_word(pop_word), .pop_ready(pop_ready),
		.credit_return(credit_return)
	);

	amp_modulator u_mod (
		.elem(elem), .reset(reset), .pop_valid(pop_valid), .pop_word(pop_word),
		.pop_ready(pop_ready), .out(out), .out_valid(out_valid), .out_ready(out_ready)
	);

endmodule

`default_nettype wire

// ==== dv/drive_checker.sv ====
// testbench checker: command model, expected sample queue, output compare and stall check
`timescale 1ns/1ns
`default_nettype none

module drive_checker (
	input  logic                      elem,
	input  logic                      reset,
	input  elem_cmd_pkg::elem_cmd_t   cmd,
	input  logic                      cmd_valid,
	input  logic                      cmd_ready,
	input  elem_dsp_pkg::out_sample_t out,
	input  logic                      out_valid,
	input  logic                      out_ready,
	input  elem_dsp_pkg::iq_t         tbl [2 ** elem_cmd_pkg::ENV_ADDR_W],
	output int                        err_cnt,
	output int                        seen_cnt,
	output int                        pending
);

	elem_dsp_pkg::out_sample_t exp_q [$];
	elem_dsp_pkg::out_sample_t held; // output seen while stalled
	elem_dsp_pkg::out_sample_t exp_s;
	logic                      stalled;
	logic                      reset_d;

	// Q1.15 complex product, rescaled and wrapped to 16 bits
	function automatic elem_dsp_pkg::iq_t complex_mult(input elem_dsp_pkg::iq_t e,
			input elem_dsp_pkg::iq_t a);
		longint re;
		longint im;
		re = longint'(e.x) * longint'(a.x) - longint'(e.y) * longint'(a.y);
		im = longint'(e.x) * longint'(a.y) + longint'(e.y) * longint'(a.x);
		complex_mult.x = 16'(re >>> 15);
		complex_mult.y = 16'(im >>> 15);
	endfunction

	// one expected sample per envelope entry, address wraps at table end
	task automatic expand(input elem_cmd_pkg::elem_cmd_t c);
		elem_dsp_pkg::out_sample_t s;
		elem_cmd_pkg::env_addr_t   a;
		a = c.env_start;
		for (int k = 0; k < int'(c.env_len); k++) begin
			s.iq   = complex_mult(tbl[a], c.amp);
			s.last = (k == int'(c.env_len) - 1);
			exp_q.push_back(s);
			a = a + 1'b1;
		end
	endtask

	// negedge sampling, everything is settled half a cycle after the edge
	always @(negedge elem) begin
		if (reset) begin
			exp_q.delete();
			stalled = 1'b0;
		end else begin
			if (reset_d && (!cmd_ready || out_valid)) begin
				$display("** Error at %0t ns: after reset cmd_ready=%b out_valid=%b",
					$time, cmd_ready, out_valid);
				err_cnt++;
			end
			if (stalled && (!out_valid || out !== held)) begin
				$display("** Error at %0t ns: output changed while stalled", $time);
				err_cnt++;
			end
			if (cmd_valid && cmd_ready) expand(cmd);
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("** Error at %0t ns: output sample with no command pending", $time);
					err_cnt++;
				end else begin
					exp_s = exp_q.pop_front();
					if (out !== exp_s) begin
						$display("** Error at %0t ns: got x=%0d y=%0d last=%b, expected x=%0d y=%0d last=%b",
							$time, out.iq.x, out.iq.y, out.last, exp_s.iq.x, exp_s.iq.y, exp_s.last);
						err_cnt++;
					end
					seen_cnt++;
				end
			end
			stalled = out_valid && !out_ready;
			held    = out;
		end
		reset_d = reset;
		pending = exp_q.size();
	end

endmodule

`default_nettype wire

// ==== dv/tb_drive_element.sv ====
// testbench top: clock, reset, table load, command sequences, per-test report and counts
`timescale 1ns/1ns
`default_nettype none

module tb_drive_element;

	localparam int TBL_SIZE = 2 ** elem_cmd_pkg::ENV_ADDR_W;
	localparam int TIMEOUT  = 4000; // cycles allowed per wait

	logic                      elem;
	logic                      reset;
	logic                      tbl_we;
	elem_cmd_pkg::env_addr_t   tbl_addr;
	elem_dsp_pkg::iq_t         tbl_data;
	elem_cmd_pkg::elem_cmd_t   cmd;
	logic                      cmd_valid;
	logic                      cmd_ready;
	elem_dsp_pkg::out_sample_t out;
	logic                      out_valid;
	logic                      out_ready;
	elem_dsp_pkg::iq_t         tbl_copy [TBL_SIZE];
	logic                      rand_ready; // random back-pressure on the output
	logic                      rand_mode;  // rand_ready as it stood at the clock edge
	logic                      test_timeout;
	int                        err_cnt;
	int                        seen_cnt;
	int                        pending;
	int                        tests_run;
	int                        tests_failed;
	int                        err_base;
	int                        seen_base;
	int                        total;
	int                        len;
	logic signed [15:0]        corner [3];

	drive_element #(.FIFO_DEPTH(4)) uut (
		.elem(elem), .reset(reset), .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_data(tbl_data),
		.cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.out(out), .out_valid(out_valid), .out_ready(out_ready)
	);

	drive_checker chk (
		.elem(elem), .reset(reset), .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.out(out), .out_valid(out_valid), .out_ready(out_ready), .tbl(tbl_copy),
		.err_cnt(err_cnt), .seen_cnt(seen_cnt), .pending(pending)
	);

	always #50 elem = ~elem;

	always @(posedge elem) begin
		rand_mode = rand_ready;
		#1;
		out_ready = rand_mode ? ($urandom_range(3) != 0) : 1'b1;
	end

	function automatic elem_dsp_pkg::iq_t rand_iq();
		rand_iq.x = 16'($urandom);
		rand_iq.y = 16'($urandom);
	endfunction

	// corner values in the first nine entries, random elsewhere
	task automatic load_table();
		for (int i = 0; i < TBL_SIZE; i++) begin
			if (i < 9) begin
				tbl_copy[i].x = corner[i % 3];
				tbl_copy[i].y = corner[i / 3];
			end else begin
				tbl_copy[i] = rand_iq();
			end
			tbl_we   = 1'b1;
			tbl_addr = elem_cmd_pkg::env_addr_t'(i);
			tbl_data = tbl_copy[i];
			@(posedge elem);
			#1;
		end
		tbl_we = 1'b0;
	endtask

	// cmd_ready only moves on an edge, so its value now is what the next edge sees
	task automatic send_cmd(input int start, input int n, input elem_dsp_pkg::iq_t amp);
		int   waited;
		logic taken;
		waited        = 0;
		taken         = 1'b0;
		cmd.env_start = elem_cmd_pkg::env_addr_t'(start);
		cmd.env_len   = (elem_cmd_pkg::ENV_ADDR_W + 1)'(n);
		cmd.amp       = amp;
		cmd_valid     = 1'b1;
		while (!taken && waited < TIMEOUT) begin
			taken = cmd_ready;
			@(posedge elem);
			#1;
			waited++;
		end
		cmd_valid = 1'b0;
		if (!taken) begin
			$display("timeout: command at start %0d was never accepted", start);
			test_timeout = 1'b1;
		end
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (!(cmd_ready && pending == 0 && !out_valid) && waited < TIMEOUT) begin
			@(posedge elem);
			#1;
			waited++;
		end
		if (waited >= TIMEOUT) begin
			$display("timeout: element did not finish its commands");
			test_timeout = 1'b1;
		end
	endtask

	function automatic logic count_ok(input int n);
		count_ok = (seen_cnt - seen_base == n);
		if (!count_ok)
			$display("** Error at %0t ns: %0d samples out, expected %0d", $time,
				seen_cnt - seen_base, n);
	endfunction

	task automatic report_test(input string name, input logic ok);
		tests_run++;
		if (ok && !test_timeout && err_cnt == err_base) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED", tests_run, name);
		end
		test_timeout = 1'b0;
		err_base     = err_cnt;
		seen_base    = seen_cnt;
	endtask

	initial begin
		void'($urandom(32'h2d95));
		corner = '{16'sh7fff, 16'sh8000, 16'sh8001};
		{elem, reset, tbl_we, cmd_valid, out_ready, rand_ready} = 6'b010010;
		tbl_addr     = '0;
		tbl_data     = '0;
		cmd          = '0;
		test_timeout = 1'b0;
		{tests_run, tests_failed, err_base, seen_base} = '0;
		repeat (4) @(posedge elem);
		#1;
		reset = 1'b0;
		@(posedge elem);
		#1;
		report_test("reset state", 1'b1);

		load_table();
		send_cmd(10, 12, rand_iq());
		wait_idle();
		report_test("single command", count_ok(12));

		total      = 0;
		rand_ready = 1'b1;
		repeat (40) begin
			len = $urandom_range(40);
			total += len;
			send_cmd($urandom_range(TBL_SIZE - 1), len, rand_iq());
		end
		wait_idle();
		rand_ready = 1'b0;
		report_test("random commands with back-pressure", count_ok(total));

		send_cmd(250, 12, rand_iq()); // crosses the table end
		send_cmd(240, 30, rand_iq());
		send_cmd(128, TBL_SIZE, rand_iq()); // whole table
		wait_idle();
		report_test("address wrap, back-to-back", count_ok(12 + 30 + TBL_SIZE));

		send_cmd(77, 0, rand_iq());
		wait_idle();
		send_cmd(5, 0, rand_iq());
		send_cmd(5, 3, rand_iq());
		wait_idle();
		report_test("zero length", count_ok(3));

		for (int i = 0; i < 9; i++) begin
			send_cmd(0, 9, '{x: corner[i % 3], y: corner[i / 3]});
		end
		wait_idle();
		report_test("full-scale values", count_ok(81));

		$display("%0d tests run, %0d failed, %0d value errors", tests_run, tests_failed, err_cnt);
		if (tests_failed == 0 && err_cnt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
src/elem_dsp_pkg.sv
src/elem_cmd_pkg.sv
src/env_table.sv
src/pulse_sequencer.sv
src/credit_fifo.sv
src/amp_modulator.sv
src/drive_element.sv
dv/drive_checker.sv
dv/tb_drive_element.sv

// ==== run.sh ====
#!/bin/sh
# build and run the drive element testbench, pass only when the log holds the pass message
rm -f sim.log
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_drive_element \
	-o sim_drive_element && ./obj_dir/sim_drive_element > sim.log 2>&1 || echo "build or run error"
cat sim.log 2>/dev/null
grep -qs "^all tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
